// File: project.f
logic/rotator_pkg.sv
logic/loop_counters.sv
logic/weight_bank.sv
logic/rotator_ctrl.sv
logic/weight_rotator.sv
dv/tb_weight_rotator.sv

// File: dv/tb_weight_rotator.sv
// Weight rotator testbench
`timescale 1ns/10ps
`default_nettype none

module tb_weight_rotator;

  localparam int NUM_TESTS    = 5;
  localparam int MEM_DEPTH    = 48;
  localparam int MAX_WORDS    = rotator_pkg::KH_MAX * rotator_pkg::CIN_MAX;
  localparam int CLK_NS       = 8;
  localparam int RESET_CYCLES = 16;
  localparam logic [15:0] SEED = 16'd29013;

  logic                aclk = 1'b0;
  logic                i_rst;
  logic                i_s_valid;
  rotator_pkg::beat_t  i_s_data;
  logic                i_s_last;
  logic                o_s_ready;
  logic                o_m_valid;
  rotator_pkg::beat_t  o_m_data;
  rotator_pkg::tuser_t o_m_user;
  logic                o_m_last;
  logic                i_m_ready;

  // frame table, one row per test.
  string                test_name [NUM_TESTS];
  rotator_pkg::header_t test_hdr  [NUM_TESTS];
  logic                 test_gaps [NUM_TESTS];

  rotator_pkg::beat_t sent_words [NUM_TESTS][MAX_WORDS];
  // last slot collects errors outside the frame tests.
  int                 errors [NUM_TESTS+1];
  int                 frames_written;
  int                 limit_ns;
  int                 tests_passed;
  int                 tests_failed;

  weight_rotator #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_weight_rotator (
    .aclk      (aclk),
    .i_rst     (i_rst),
    .i_s_valid (i_s_valid),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .o_s_ready (o_s_ready),
    .o_m_valid (o_m_valid),
    .o_m_data  (o_m_data),
    .o_m_user  (o_m_user),
    .o_m_last  (o_m_last),
    .i_m_ready (i_m_ready)
  );

  always #(CLK_NS / 2) aclk = ~aclk;

  // fibonacci lfsr, taps 16 14 13 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int word_count(input rotator_pkg::header_t h);
    return (int'(h.kh_1) + 1) * (int'(h.cin_1) + 1);
  endfunction

  function automatic int pass_count(input rotator_pkg::header_t h);
    return (int'(h.cols_1) + 1) * (int'(h.blocks_1) + 1);
  endfunction

  task automatic set_row(input int idx, input string name, input int blocks_1,
                         input int cols_1, input int cin_1, input int kh_1,
                         input int kw_1, input logic gaps);
    test_name[idx]          = name;
    test_hdr[idx].blocks_1  = rotator_pkg::BITS_BLOCKS'(blocks_1);
    test_hdr[idx].cols_1    = rotator_pkg::BITS_COLS'(cols_1);
    test_hdr[idx].cin_1     = rotator_pkg::BITS_CIN'(cin_1);
    test_hdr[idx].kh_1      = rotator_pkg::BITS_KH'(kh_1);
    test_hdr[idx].kw_1      = rotator_pkg::BITS_KW'(kw_1);
    test_gaps[idx]          = gaps;
  endtask

  task automatic load_table;
    set_row(0, "k3x3_two_blocks",  1, 2, 1,  2, 2, 1'b0);
    set_row(1, "k1x1_cin5",        0, 3, 4,  0, 0, 1'b0);
    set_row(2, "k3x3_ready_gaps",  3, 1, 2,  2, 2, 1'b1);
    set_row(3, "k3x3_full_bank",   0, 0, 15, 2, 2, 1'b1);
    set_row(4, "k2x3_many_passes", 3, 7, 0,  2, 1, 1'b1);
  endtask

  task automatic check_value(input int slot, input string what,
                             input logic [63:0] exp, input logic [63:0] got);
    string name;
    name = (slot < NUM_TESTS) ? test_name[slot] : "reset";
    assert (got === exp) else begin
      $display("Mismatch %s %s: expected %h, actual %h", name, what, exp, got);
      errors[slot]++;
    end
  endtask

  task automatic next_cycle;
    @(posedge aclk);
    #1;
  endtask

  // holds one input beat until the DUT takes it.
  task automatic push_beat(input rotator_pkg::beat_t data, input logic last);
    logic taken;
    i_s_valid = 1'b1;
    i_s_data  = data;
    i_s_last  = last;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge aclk);
      taken = o_s_ready;
      next_cycle();
    end
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
  endtask

  task automatic drive_frames;
    logic [15:0]        st;
    rotator_pkg::beat_t word;
    rotator_pkg::beat_t hbeat;
    int                 n;
    st = SEED;
    for (int f = 0; f < NUM_TESTS; f++) begin
      n     = word_count(test_hdr[f]);
      hbeat = '0;
      hbeat[$bits(rotator_pkg::header_t)-1:0] = test_hdr[f];
      push_beat(hbeat, 1'b0);
      for (int w = 0; w < n; w++) begin
        for (int b = 0; b < rotator_pkg::BEAT_WIDTH; b++) begin
          st      = lfsr_next(st);
          word[b] = st[0];
        end
        sent_words[f][w] = word;
        // idle input cycles on gap rows.
        if (test_gaps[f]) begin
          st = lfsr_next(st);
          if (!st[0]) begin
            next_cycle();
          end
        end
        push_beat(word, w == n - 1);
      end
      frames_written++;
    end
  endtask

  task automatic check_frames;
    logic [15:0]          st;
    rotator_pkg::header_t h;
    rotator_pkg::tuser_t  exp_user;
    int                   n_words;
    int                   n_pass;
    int                   cols_cnt;
    int                   blk_cnt;
    int                   beats;
    logic                 got;
    logic                 early;
    st = SEED;
    for (int f = 0; f < NUM_TESTS; f++) begin
      h       = test_hdr[f];
      n_words = word_count(h);
      n_pass  = pass_count(h);
      beats   = 0;
      early   = 1'b0;
      for (int p = 0; p < n_pass; p++) begin
        // outer counters count down once per replay pass.
        cols_cnt = int'(h.cols_1) - (p % (int'(h.cols_1) + 1));
        blk_cnt  = int'(h.blocks_1) - (p / (int'(h.cols_1) + 1));
        for (int w = 0; w < n_words; w++) begin
          exp_user.kw_1            = h.kw_1;
          exp_user.is_acc_last     = (w == n_words - 1);
          exp_user.is_cols_1_k2    = (cols_cnt == int'(h.kw_1) / 2);
          exp_user.is_1x1          = (h.kw_1 == '0);
          exp_user.is_bottom_block = (blk_cnt == 0);
          exp_user.is_top_block    = (blk_cnt == int'(h.blocks_1));
          got = 1'b0;
          while (!got) begin
            if (test_gaps[f]) begin
              st        = lfsr_next(st);
              i_m_ready = st[0];
            end else begin
              i_m_ready = 1'b1;
            end
            @(negedge aclk);
            if (!early) begin
              assert (!(o_m_valid && (frames_written <= f))) else begin
                $display("output valid before frame %s was fully written", test_name[f]);
                errors[f]++;
                early = 1'b1;
              end
            end
            if (o_m_valid && i_m_ready) begin
              got = 1'b1;
              check_value(f, $sformatf("data pass %0d word %0d", p, w),
                          sent_words[f][w], o_m_data);
              check_value(f, $sformatf("user pass %0d word %0d", p, w), exp_user, o_m_user);
              check_value(f, $sformatf("last pass %0d word %0d", p, w),
                          (p == n_pass - 1) && (w == n_words - 1), o_m_last);
              beats++;
            end
            next_cycle();
          end
        end
      end
      $display("test %s: %0d beats, %0d errors, %s", test_name[f], beats, errors[f],
               (errors[f] == 0) ? "PASS" : "FAIL");
    end
    i_m_ready = 1'b1;
    // nothing may follow the final frame.
    repeat (8) begin
      @(negedge aclk);
      assert (!o_m_valid) else begin
        $display("extra output beat after the last frame");
        errors[NUM_TESTS]++;
      end
    end
  endtask

  initial begin
    i_rst          = 1'b1;
    i_s_valid      = 1'b0;
    i_s_data       = '0;
    i_s_last       = 1'b0;
    i_m_ready      = 1'b0;
    frames_written = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    for (int i = 0; i <= NUM_TESTS; i++) begin
      errors[i] = 0;
    end
    load_table();

    // four cycles per expected beat on both streams.
    limit_ns = RESET_CYCLES * CLK_NS;
    for (int f = 0; f < NUM_TESTS; f++) begin
      limit_ns += 4 * CLK_NS * (word_count(test_hdr[f]) * pass_count(test_hdr[f])
                                + word_count(test_hdr[f]) + 1);
    end
    fork
      begin
        #(limit_ns);
        $display("timeout: the run did not finish within %0d ns", limit_ns);
        $display("sim failed");
        $finish;
      end
    join_none

    repeat (RESET_CYCLES) @(posedge aclk);
    #1;
    i_rst = 1'b0;
    @(negedge aclk);
    check_value(NUM_TESTS, "o_s_ready", 64'd0, o_s_ready);
    check_value(NUM_TESTS, "o_m_valid", 64'd0, o_m_valid);
    next_cycle();

    fork
      drive_frames();
      check_frames();
    join

    for (int f = 0; f < NUM_TESTS; f++) begin
      if (errors[f] == 0) begin
        tests_passed++;
      end else begin
        tests_failed++;
      end
    end
    $display("summary: %0d tests passed, %0d tests failed, %0d other errors",
             tests_passed, tests_failed, errors[NUM_TESTS]);
    if ((tests_failed == 0) && (errors[NUM_TESTS] == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/weight_rotator.sv
// Weight rotator top level
`timescale 1ns/10ps
`default_nettype none

module weight_rotator #(
  parameter int MEM_DEPTH = 48
) (
  input  logic                aclk,
  input  logic                i_rst,
  input  logic                i_s_valid,
  input  rotator_pkg::beat_t  i_s_data,
  input  logic                i_s_last,
  output logic                o_s_ready,
  output logic                o_m_valid,
  output rotator_pkg::beat_t  o_m_data,
  output rotator_pkg::tuser_t o_m_user,
  output logic                o_m_last,
  input  logic                i_m_ready
);

  rotator_pkg::header_t                     s_header;
  rotator_pkg::header_t                     rd_header;
  rotator_pkg::beat_t [1:0]                 bank_rdata;
  logic [1:0]                               bank_valid;
  logic [1:0]                               wen;
  logic [1:0]                               clear;
  logic [1:0]                               advance;
  logic [1:0][rotator_pkg::BITS_ADDR-1:0]   last_addr;
  logic                                     rd_sel;
  logic                                     count_start;
  logic                                     count_done;
  logic                                     m_step;

  // header occupies the low bits of a full width beat.
  assign s_header = i_s_data[$bits(rotator_pkg::header_t)-1:0];
  assign m_step   = o_m_valid && i_m_ready;
  assign o_m_data = bank_rdata[rd_sel];

  rotator_ctrl u_ctrl (
    .aclk          (aclk),
    .i_rst         (i_rst),
    .i_s_valid     (i_s_valid),
    .i_s_last      (i_s_last),
    .i_s_header    (s_header),
    .i_m_ready     (i_m_ready),
    .i_bank_valid  (bank_valid),
    .i_count_done  (count_done),
    .o_s_ready     (o_s_ready),
    .o_m_valid     (o_m_valid),
    .o_wen         (wen),
    .o_clear       (clear),
    .o_advance     (advance),
    .o_last_addr   (last_addr),
    .o_rd_header   (rd_header),
    .o_rd_sel      (rd_sel),
    .o_count_start (count_start)
  );

  for (genvar b = 0; b < 2; b++) begin : g_bank
    weight_bank #(
      .MEM_DEPTH (MEM_DEPTH)
    ) u_bank (
      .aclk        (aclk),
      .i_rst       (i_rst),
      .i_clear     (clear[b]),
      .i_wen       (wen[b]),
      .i_wdata     (i_s_data),
      .i_last_addr (last_addr[b]),
      .i_advance   (advance[b]),
      .o_rdata     (bank_rdata[b]),
      .o_valid     (bank_valid[b])
    );
  end

  loop_counters u_counters (
    .aclk     (aclk),
    .i_rst    (i_rst),
    .i_start  (count_start),
    .i_step   (m_step),
    .i_header (rd_header),
    .o_user   (o_m_user),
    .o_last   (o_m_last),
    .o_done   (count_done)
  );

endmodule

`default_nettype wire

// File: logic/rotator_ctrl.sv
// Ping-pong bank control
`timescale 1ns/10ps
`default_nettype none

module rotator_ctrl (
  input  logic                                   aclk,
  input  logic                                   i_rst,
  input  logic                                   i_s_valid,
  input  logic                                   i_s_last,
  input  rotator_pkg::header_t                   i_s_header,
  input  logic                                   i_m_ready,
  input  logic [1:0]                             i_bank_valid,
  input  logic                                   i_count_done,
  output logic                                   o_s_ready,
  output logic                                   o_m_valid,
  output logic [1:0]                             o_wen,
  output logic [1:0]                             o_clear,
  output logic [1:0]                             o_advance,
  output logic [1:0][rotator_pkg::BITS_ADDR-1:0] o_last_addr,
  output rotator_pkg::header_t                   o_rd_header,
  output logic                                   o_rd_sel,
  output logic                                   o_count_start
);

  rotator_pkg::wstate_e                   wstate;
  rotator_pkg::wstate_e                   wstate_next;
  rotator_pkg::rstate_e                   rstate;
  rotator_pkg::rstate_e                   rstate_next;
  logic                                   wr_sel;
  logic                                   rd_sel;
  logic [1:0]                             done_write;
  logic [1:0]                             done_read;
  logic                                   s_ready_q;
  logic                                   header_hs;
  logic                                   weight_hs;
  rotator_pkg::header_t [1:0]             header_q;
  logic [1:0][rotator_pkg::BITS_ADDR-1:0] last_addr_q;
  logic [rotator_pkg::BITS_ADDR-1:0]      last_addr_new;
  logic [rotator_pkg::BITS_ADDR-1:0]      weight_count;

  assign header_hs = i_s_valid && s_ready_q && (wstate == rotator_pkg::W_HEADER);
  assign weight_hs = i_s_valid && s_ready_q && (wstate == rotator_pkg::W_WRITE);

  // (kh+1)*(cin+1)-1 expanded to avoid the extra adder stage.
  assign last_addr_new =
      rotator_pkg::BITS_ADDR'(i_s_header.kh_1) * rotator_pkg::BITS_ADDR'(i_s_header.cin_1)
      + rotator_pkg::BITS_ADDR'(i_s_header.kh_1)
      + rotator_pkg::BITS_ADDR'(i_s_header.cin_1);

  always_comb begin
    wstate_next = wstate;
    case (wstate)
      rotator_pkg::W_IDLE:   if (done_read[wr_sel]) wstate_next = rotator_pkg::W_HEADER;
      rotator_pkg::W_HEADER: if (header_hs) wstate_next = rotator_pkg::W_WRITE;
      rotator_pkg::W_WRITE:  if (weight_hs && i_s_last) wstate_next = rotator_pkg::W_SWITCH;
      default:               wstate_next = rotator_pkg::W_IDLE;
    endcase
  end

  always_comb begin
    rstate_next = rstate;
    case (rstate)
      rotator_pkg::R_IDLE: if (done_write[rd_sel]) rstate_next = rotator_pkg::R_READ;
      rotator_pkg::R_READ: if (i_count_done) rstate_next = rotator_pkg::R_SWITCH;
      default:             rstate_next = rotator_pkg::R_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      wstate       <= rotator_pkg::W_IDLE;
      rstate       <= rotator_pkg::R_IDLE;
      wr_sel       <= 1'b0;
      rd_sel       <= 1'b0;
      done_write   <= 2'b00;
      done_read    <= 2'b11;
      s_ready_q    <= 1'b0;
      weight_count <= '0;
    end else begin
      wstate    <= wstate_next;
      rstate    <= rstate_next;
      // ready follows the header state by one cycle, then holds for the weights.
      s_ready_q <= ((wstate == rotator_pkg::W_HEADER) && !header_hs)
                   || (wstate_next == rotator_pkg::W_WRITE);
      if (header_hs) begin
        weight_count <= '0;
      end else if (weight_hs) begin
        weight_count <= weight_count + 1'b1;
      end
      // a free bank is claimed by the writer, a full bank by the reader.
      if ((wstate == rotator_pkg::W_IDLE) && done_read[wr_sel]) begin
        done_read[wr_sel] <= 1'b0;
      end
      if ((rstate == rotator_pkg::R_IDLE) && done_write[rd_sel]) begin
        done_write[rd_sel] <= 1'b0;
      end
      if (wstate == rotator_pkg::W_SWITCH) begin
        done_write[wr_sel] <= 1'b1;
        wr_sel             <= !wr_sel;
      end
      if (rstate == rotator_pkg::R_SWITCH) begin
        done_read[rd_sel] <= 1'b1;
        rd_sel            <= !rd_sel;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (header_hs) begin
      header_q[wr_sel]    <= i_s_header;
      last_addr_q[wr_sel] <= last_addr_new;
    end
  end

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      o_wen[b]     = weight_hs && (wr_sel == 1'(b));
      o_clear[b]   = header_hs && (wr_sel == 1'(b));
      o_advance[b] = (rstate == rotator_pkg::R_READ) && i_m_ready && (rd_sel == 1'(b));
    end
  end

  assign o_s_ready     = s_ready_q;
  assign o_m_valid     = (rstate == rotator_pkg::R_READ) && i_bank_valid[rd_sel];
  assign o_last_addr   = last_addr_q;
  assign o_rd_header   = header_q[rd_sel];
  assign o_rd_sel      = rd_sel;
  assign o_count_start = (rstate == rotator_pkg::R_IDLE) && done_write[rd_sel];

  // the frame must close on exactly its last weight beat.
  a_last_on_final_beat : assert property (@(posedge aclk) disable iff (i_rst)
    weight_hs |-> (i_s_last == (weight_count == last_addr_q[wr_sel])));

  // writer and reader never hold one bank together.
  a_bank_exclusive : assert property (@(posedge aclk) disable iff (i_rst)
    ((wstate != rotator_pkg::W_IDLE) && (rstate != rotator_pkg::R_IDLE)) |-> (wr_sel != rd_sel));

endmodule

`default_nettype wire

// File: logic/weight_bank.sv
// Cyclic weight bank
`timescale 1ns/10ps
`default_nettype none

module weight_bank #(
  parameter int MEM_DEPTH = 48
) (
  input  logic                              aclk,
  input  logic                              i_rst,
  input  logic                              i_clear,
  input  logic                              i_wen,
  input  rotator_pkg::beat_t                i_wdata,
  input  logic [rotator_pkg::BITS_ADDR-1:0] i_last_addr,
  input  logic                              i_advance,
  output rotator_pkg::beat_t                o_rdata,
  output logic                              o_valid
);

  rotator_pkg::beat_t                mem [MEM_DEPTH];
  logic [rotator_pkg::BITS_ADDR-1:0] wr_ptr;
  logic [rotator_pkg::BITS_ADDR-1:0] rd_ptr;
  logic [rotator_pkg::BITS_ADDR-1:0] rd_ptr_next;
  logic                              full;
  logic                              load;

  // output register refills when empty or when its word is taken.
  assign load = full && (!o_valid || i_advance);

  // read side runs cyclically over the stored words.
  assign rd_ptr_next = (rd_ptr == i_last_addr) ? '0 : rd_ptr + 1'b1;

  always_ff @(posedge aclk) begin
    if (i_wen) begin
      mem[wr_ptr] <= i_wdata;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      o_rdata <= mem[rd_ptr];
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst || i_clear) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      full    <= 1'b0;
      o_valid <= 1'b0;
    end else begin
      if (i_wen) begin
        wr_ptr <= wr_ptr + 1'b1;
        // bank is complete once the last address is written.
        if (wr_ptr == i_last_addr) begin
          full <= 1'b1;
        end
      end
      if (load) begin
        rd_ptr  <= rd_ptr_next;
        o_valid <= 1'b1;
      end
    end
  end

  // writes stop at the limit given by the header.
  a_no_overrun : assert property (@(posedge aclk) disable iff (i_rst)
    i_wen |-> (!full && (wr_ptr <= i_last_addr)));

endmodule

`default_nettype wire

// File: logic/loop_counters.sv
// Replay loop counters
`timescale 1ns/10ps
`default_nettype none

module loop_counters (
  input  logic                 aclk,
  input  logic                 i_rst,
  input  logic                 i_start,
  input  logic                 i_step,
  input  rotator_pkg::header_t i_header,
  output rotator_pkg::tuser_t  o_user,
  output logic                 o_last,
  output logic                 o_done
);

  // level 0 is kh, then cin, cols and blocks outermost.
  localparam int LEVELS = 4;
  localparam int W_INNER = (rotator_pkg::BITS_KH > rotator_pkg::BITS_CIN)
                           ? rotator_pkg::BITS_KH : rotator_pkg::BITS_CIN;
  localparam int W_OUTER = (rotator_pkg::BITS_COLS > rotator_pkg::BITS_BLOCKS)
                           ? rotator_pkg::BITS_COLS : rotator_pkg::BITS_BLOCKS;
  localparam int CNT_W = (W_INNER > W_OUTER) ? W_INNER : W_OUTER;

  logic [LEVELS-1:0][CNT_W-1:0] limit;
  logic [LEVELS-1:0][CNT_W-1:0] count;
  logic [LEVELS-1:0]            last;
  logic [LEVELS-1:0]            en;

  assign limit[0] = CNT_W'(i_header.kh_1);
  assign limit[1] = CNT_W'(i_header.cin_1);
  assign limit[2] = CNT_W'(i_header.cols_1);
  assign limit[3] = CNT_W'(i_header.blocks_1);

  // each level steps when every inner level wraps.
  always_comb begin
    en[0] = i_step;
    for (int i = 1; i < LEVELS; i++) begin
      en[i] = en[i-1] && last[i-1];
    end
  end

  always_ff @(posedge aclk) begin
    if (i_rst) begin
      count <= '0;
      last  <= '0;
    end else if (i_start) begin
      count <= limit;
      for (int i = 0; i < LEVELS; i++) begin
        last[i] <= (limit[i] == '0);
      end
    end else if (o_done) begin
      // frame finished, keep last low until the next start.
      last <= '0;
    end else begin
      for (int i = 0; i < LEVELS; i++) begin
        if (en[i]) begin
          if (last[i]) begin
            count[i] <= limit[i];
            last[i]  <= (limit[i] == '0);
          end else begin
            count[i] <= count[i] - 1'b1;
            last[i]  <= (count[i] == CNT_W'(1));
          end
        end
      end
    end
  end

  assign o_last = &last;
  assign o_done = i_step && o_last;

  // sideband flags for the convolution engine.
  assign o_user.kw_1            = i_header.kw_1;
  assign o_user.is_acc_last     = last[0] && last[1];
  assign o_user.is_cols_1_k2    = (count[2] == CNT_W'(i_header.kw_1 >> 1));
  assign o_user.is_1x1          = (i_header.kw_1 == '0);
  assign o_user.is_bottom_block = last[3];
  assign o_user.is_top_block    = (count[3] == limit[3]);

endmodule

`default_nettype wire

// File: logic/rotator_pkg.sv
// Weight rotator shared types
`default_nettype none

package rotator_pkg;

  // core and kernel geometry.
  localparam int CORES      = 2;
  localparam int WORD_WIDTH = 8;
  localparam int KW_MAX     = 3;
  localparam int KH_MAX     = 3;
  localparam int CIN_MAX    = 16;
  localparam int COLS_MAX   = 8;
  localparam int BLOCKS_MAX = 4;

  // header field widths, each field holds its count minus one.
  localparam int BITS_KW     = $clog2(KW_MAX);
  localparam int BITS_KH     = $clog2(KH_MAX);
  localparam int BITS_CIN    = $clog2(CIN_MAX);
  localparam int BITS_COLS   = $clog2(COLS_MAX);
  localparam int BITS_BLOCKS = $clog2(BLOCKS_MAX);

  localparam int BITS_ADDR  = 6;
  localparam int BEAT_WIDTH = CORES * KW_MAX * WORD_WIDTH;

  typedef logic [BEAT_WIDTH-1:0] beat_t;

  // first beat of a frame, taken from the low bits of the data.
  typedef struct packed {
    logic [BITS_BLOCKS-1:0] blocks_1;
    logic [BITS_COLS-1:0]   cols_1;
    logic [BITS_CIN-1:0]    cin_1;
    logic [BITS_KH-1:0]     kh_1;
    logic [BITS_KW-1:0]     kw_1;
  } header_t;

  // output sideband, top block sits in bit 0.
  typedef struct packed {
    logic [BITS_KW-1:0] kw_1;
    logic               is_acc_last;
    logic               is_cols_1_k2;
    logic               is_1x1;
    logic               is_bottom_block;
    logic               is_top_block;
  } tuser_t;

  typedef enum logic [1:0] {
    W_IDLE,
    W_HEADER,
    W_WRITE,
    W_SWITCH
  } wstate_e;

  typedef enum logic [1:0] {
    R_IDLE,
    R_READ,
    R_SWITCH
  } rstate_e;

endpackage

`default_nettype wire
